//--- Bender.yml
package:
  name: cpu16

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_pkg.sv
      - design/imem.sv
      - design/pc_ctrl.sv
      - design/reg_file.sv
      - design/alu.sv
      - design/mem_unit.sv
      - design/cpu.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/cpu_tb.sv

//--- design/alu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module alu (
  input  logic             clk,
  input  logic             rst_n,
  input  cpu_pkg::opcode_e opcode,
  input  cpu_pkg::word_t   op_a,
  input  cpu_pkg::word_t   op_b,
  input  logic [3:0]       shamt,
  output cpu_pkg::word_t   result,
  output cpu_pkg::flags_t  flags
);

  import cpu_pkg::*;

  localparam int MSB = `CPU_WORD_W - 1;

  logic sign_a;
  logic sign_b;
  logic sign_r;
  logic ovf;
  logic z_we;
  logic nv_we;

  // operation select
  always_comb begin
    case (opcode)
      OP_ADD:  result = op_a + op_b;
      OP_SUB:  result = op_a - op_b;
      OP_XOR:  result = op_a ^ op_b;
      OP_AND:  result = op_a & op_b;
      OP_OR:   result = op_a | op_b;
      OP_SLL:  result = op_a << shamt;
      OP_SRL:  result = op_a >> shamt;
      // arithmetic right shift keeps the sign bit
      OP_SRA:  result = word_t'($signed(op_a) >>> shamt);
      default: result = '0;
    endcase
  end

  // sign bits for overflow detection
  assign sign_a = op_a[MSB];
  assign sign_b = op_b[MSB];
  assign sign_r = result[MSB];

  // add overflows when like signs give an unlike result
  // sub overflows when unlike signs give a result unlike op_a
  always_comb begin
    case (opcode)
      OP_ADD:  ovf = (sign_a == sign_b) && (sign_r != sign_a);
      OP_SUB:  ovf = (sign_a != sign_b) && (sign_r != sign_a);
      default: ovf = 1'b0;
    endcase
  end

  // Z on opcodes 0 to 7, N and V on ADD and SUB only
  assign z_we  = ~opcode[3];
  assign nv_we = (opcode == OP_ADD) || (opcode == OP_SUB);

  // flag register, bits N, Z, V
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else begin
      if (z_we) begin
        flags[1] <= (result == '0);
      end
      if (nv_we) begin
        flags[2] <= sign_r;
        flags[0] <= ovf;
      end
    end
  end

endmodule

//--- design/cpu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                prog_we,
  input  cpu_pkg::imem_addr_t prog_addr,
  input  cpu_pkg::word_t      prog_data,
  output cpu_pkg::word_t      pc,
  output logic                hlt,
  output logic                st_en,
  output cpu_pkg::word_t      st_addr,
  output cpu_pkg::word_t      st_data
);

  import cpu_pkg::*;

  word_t    instr;
  opcode_e  opcode;
  reg_idx_t rd;
  reg_idx_t rs;
  reg_idx_t rt;
  cond_t    cond;
  logic     mem_op;
  logic     byte_op;
  logic     store_op;
  logic     reg_we;
  word_t    rs_data;
  word_t    rt_data;
  word_t    alu_out;
  word_t    load_data;
  word_t    byte_ins;
  word_t    wb_data;
  word_t    pc_plus2;
  flags_t   flags;

  // program memory, fetched at pc
  imem u_imem (
    .clk        (clk),
    .fetch_addr (pc),
    .instr      (instr),
    .load_en    (prog_we),
    .load_addr  (prog_addr),
    .load_data  (prog_data)
  );

  // instruction fields
  assign opcode = opcode_e'(instr[15:12]);
  assign rd     = instr[11:8];
  assign cond   = instr[11:9];

  // LW and SW share 100x, LLB and LHB share 101x
  assign mem_op  = (instr[15:13] == 3'b100);
  assign byte_op = (instr[15:13] == 3'b101);

  // byte inserts read the old rd through port a
  assign rs = byte_op ? instr[11:8] : instr[7:4];
  // store data register sits in the rd field
  assign rt = mem_op ? instr[11:8] : instr[3:0];

  assign hlt      = (opcode == OP_HLT);
  assign store_op = (opcode == OP_SW);

  // no register write on stores, branches or halt
  assign reg_we = !(store_op || (opcode == OP_B) || (opcode == OP_BR) || hlt);

  // pc, branch decision and halt hold
  pc_ctrl u_pc (
    .clk      (clk),
    .rst_n    (rst_n),
    .opcode   (opcode),
    .cond     (cond),
    .br_imm   (instr[8:0]),
    .rs_data  (rs_data),
    .flags    (flags),
    .pc       (pc),
    .pc_plus2 (pc_plus2)
  );

  reg_file u_rf (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_idx_a  (rs),
    .rd_idx_b  (rt),
    .rd_data_a (rs_data),
    .rd_data_b (rt_data),
    .wr_en     (reg_we),
    .wr_idx    (rd),
    .wr_data   (wb_data)
  );

  // shift amount shares the rt field
  alu u_alu (
    .clk    (clk),
    .rst_n  (rst_n),
    .opcode (opcode),
    .op_a   (rs_data),
    .op_b   (rt_data),
    .shamt  (instr[3:0]),
    .result (alu_out),
    .flags  (flags)
  );

  // store bus held quiet while the program is being loaded
  assign st_en   = rst_n & store_op;
  assign st_data = rt_data;

  mem_unit u_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .base    (rs_data),
    .offset  (instr[3:0]),
    .wr_en   (st_en),
    .wr_data (rt_data),
    .addr    (st_addr),
    .rd_data (load_data)
  );

  // LLB keeps the high byte, LHB keeps the low byte
  assign byte_ins = instr[12] ? {instr[7:0], rs_data[7:0]}
                              : {rs_data[`CPU_WORD_W-1:8], instr[7:0]};

  // write-back source
  always_comb begin
    case (opcode)
      OP_LW:         wb_data = load_data;
      OP_LLB, OP_LHB: wb_data = byte_ins;
      OP_PCS:        wb_data = pc_plus2;
      default:       wb_data = alu_out;
    endcase
  end

endmodule

//--- design/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data word and instruction width
`define CPU_WORD_W 16

// program memory word address width
`define CPU_IMEM_AW 8

// data memory word address width
`define CPU_DMEM_AW 8

// general register count, register 0 reads zero
`define CPU_NREGS 16

`endif

//--- design/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

  // one data word, instruction, pc or byte address
  typedef logic [`CPU_WORD_W-1:0] word_t;

  // register file index
  typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

  // flag vector, bit 2 is N, bit 1 is Z, bit 0 is V
  typedef logic [2:0] flags_t;

  // branch condition code from instr[11:9]
  typedef logic [2:0] cond_t;

  // program memory word index on the load port
  typedef logic [`CPU_IMEM_AW-1:0] imem_addr_t;

  // opcode field instr[15:12]
  typedef enum logic [3:0] {
    // register-register arithmetic, writes N, Z and V
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    // logic ops, write Z only
    OP_XOR = 4'h2,
    OP_AND = 4'h3,
    // shifts by instr[3:0], write Z only
    OP_SLL = 4'h4,
    OP_SRL = 4'h5,
    OP_SRA = 4'h6,
    OP_OR  = 4'h7,
    // word load and store
    OP_LW  = 4'h8,
    OP_SW  = 4'h9,
    // byte inserts into rd
    OP_LLB = 4'hA,
    OP_LHB = 4'hB,
    // relative and register branches
    OP_B   = 4'hC,
    OP_BR  = 4'hD,
    // rd gets pc+2
    OP_PCS = 4'hE,
    // halt, pc holds
    OP_HLT = 4'hF
  } opcode_e;

endpackage

//--- design/imem.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module imem (
  input  logic                clk,
  input  cpu_pkg::word_t      fetch_addr,
  output cpu_pkg::word_t      instr,
  input  logic                load_en,
  input  cpu_pkg::imem_addr_t load_addr,
  input  cpu_pkg::word_t      load_data
);

  import cpu_pkg::*;

  localparam int DEPTH = 1 << `CPU_IMEM_AW;

  imem_addr_t fetch_idx;

  // program words, kept across reset
  word_t mem [0:DEPTH-1];

  // pc is a byte address, bit 0 ignored
  assign fetch_idx = fetch_addr[`CPU_IMEM_AW:1];

  // fetch port
  assign instr = mem[fetch_idx];

  // load port, one word per edge
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

endmodule

//--- design/mem_unit.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module mem_unit (
  input  logic           clk,
  input  logic           rst_n,
  input  cpu_pkg::word_t base,
  input  logic [3:0]     offset,
  input  logic           wr_en,
  input  cpu_pkg::word_t wr_data,
  output cpu_pkg::word_t addr,
  output cpu_pkg::word_t rd_data
);

  import cpu_pkg::*;

  localparam int DEPTH = 1 << `CPU_DMEM_AW;

  word_t                  base_even;
  word_t                  offset_ext;
  logic [`CPU_DMEM_AW-1:0] word_idx;

  // data array, word organised
  word_t mem [0:DEPTH-1];

  // base is forced to an even byte address
  assign base_even = {base[`CPU_WORD_W-1:1], 1'b0};

  // signed word offset scaled to bytes
  assign offset_ext = {{(`CPU_WORD_W-5){offset[3]}}, offset, 1'b0};

  assign addr = base_even + offset_ext;

  // drop the byte bit, upper address bits wrap
  assign word_idx = addr[`CPU_DMEM_AW:1];

  // combinational read
  assign rd_data = mem[word_idx];

  // store lands on the closing edge of the SW cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[word_idx] <= wr_data;
    end
  end

endmodule

//--- design/pc_ctrl.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module pc_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  cpu_pkg::opcode_e opcode,
  input  cpu_pkg::cond_t   cond,
  input  logic [8:0]       br_imm,
  input  cpu_pkg::word_t   rs_data,
  input  cpu_pkg::flags_t  flags,
  output cpu_pkg::word_t   pc,
  output cpu_pkg::word_t   pc_plus2
);

  import cpu_pkg::*;

  logic  flag_n;
  logic  flag_z;
  logic  flag_v;
  logic  taken;
  word_t br_target;
  word_t pc_next;

  // unpack the flag register, ordered N, Z, V
  assign flag_n = flags[2];
  assign flag_z = flags[1];
  assign flag_v = flags[0];

  // sequential fetch address
  assign pc_plus2 = pc + word_t'(2);

  // relative target is pc+2 plus the sign-extended word offset
  assign br_target = pc_plus2 + {{(`CPU_WORD_W-10){br_imm[8]}}, br_imm, 1'b0};

  // condition table, shared by B and BR
  always_comb begin
    case (cond)
      3'b000:  taken = ~flag_z;
      3'b001:  taken = flag_z;
      3'b010:  taken = ~flag_z & ~flag_n;
      3'b011:  taken = flag_n;
      3'b100:  taken = flag_z | ~flag_n;
      3'b101:  taken = flag_n | flag_z;
      3'b110:  taken = flag_v;
      default: taken = 1'b1;
    endcase
  end

  // next pc select
  always_comb begin
    pc_next = pc_plus2;
    if (opcode == OP_HLT) begin
      // halt keeps refetching the same word
      pc_next = pc;
    end else if (opcode == OP_B && taken) begin
      pc_next = br_target;
    end else if (opcode == OP_BR && taken) begin
      // register target taken as is
      pc_next = rs_data;
    end
  end

  // pc register, updates every edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module reg_file (
  input  logic              clk,
  input  logic              rst_n,
  input  cpu_pkg::reg_idx_t rd_idx_a,
  input  cpu_pkg::reg_idx_t rd_idx_b,
  output cpu_pkg::word_t    rd_data_a,
  output cpu_pkg::word_t    rd_data_b,
  input  logic              wr_en,
  input  cpu_pkg::reg_idx_t wr_idx,
  input  cpu_pkg::word_t    wr_data
);

  import cpu_pkg::*;

  // register storage, entry 0 stays at its reset value
  word_t regs [0:`CPU_NREGS-1];

  // write port, index 0 writes are dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_idx != '0)) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // combinational read ports
  // no write-through, a write shows up on the next cycle
  assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
  assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

endmodule

//--- tb.f
+incdir+design
design/cpu_pkg.sv
design/imem.sv
design/pc_ctrl.sv
design/reg_file.sv
design/alu.sv
design/mem_unit.sv
design/cpu.sv
verification/cpu_tb.sv

//--- verification/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

  import cpu_pkg::*;

  localparam int NTESTS = 24;
  // one reset and load phase plus at most 15 instructions and 4 halt cycles
  localparam int LIMIT  = NTESTS * 40;

  logic       clk;
  logic       rst_n;
  logic       prog_we;
  imem_addr_t prog_addr;
  word_t      prog_data;
  word_t      pc;
  logic       hlt;
  logic       st_en;
  word_t      st_addr;
  word_t      st_data;

  integer seed;
  int     cycles;
  int     errors;
  int     pass_cnt;
  int     fail_cnt;

  // program image and instruction set model state
  word_t prog [0:15];
  word_t rf [0:15];
  word_t dm [0:255];
  logic  flag_n;
  logic  flag_z;
  logic  flag_v;
  word_t exp_addr [$];
  word_t exp_data [$];
  int    model_count;
  word_t model_pc;

  cpu u_dut (.*);

  always #5 clk = ~clk;

  // global run guard
  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // branch condition table on the model flags
  function automatic logic cond_met(input cond_t c);
    case (c)
      3'd0:    return !flag_z;
      3'd1:    return flag_z;
      3'd2:    return !flag_z && !flag_n;
      3'd3:    return flag_n;
      3'd4:    return flag_z || !flag_n;
      3'd5:    return flag_n || flag_z;
      3'd6:    return flag_v;
      default: return 1'b1;
    endcase
  endfunction

  // 14 random words followed by halt at word 14 and a spare halt at word 15
  task automatic gen_program();
    int          i;
    int          k;
    int          t;
    logic [31:0] r;
    logic [3:0]  op;
    reg_idx_t    rr;
    word_t       last_sw;
    bit          no_land [0:15];
    bit          br_llb [0:15];
    i = 0;
    last_sw = 16'h9000;
    for (t = 0; t < 16; t++) begin
      no_land[t] = 1'b0;
      br_llb[t]  = 1'b0;
    end
    while (i < 14) begin
      r  = $random(seed);
      op = r[15:12];
      rr = (r[11:8] == 4'd0) ? 4'd13 : r[11:8];
      if (op == OP_HLT) op = OP_SW;
      // BR needs three slots
      if (op == OP_BR && i > 11) op = OP_ADD;
      if (op == OP_B) begin
        // forward only with the target no later than the halt word
        k = $unsigned($random(seed)) % (14 - i);
        prog[i] = {4'hC, r[11:9], k[8:0]};
        i++;
      end else if (op == OP_BR) begin
        k = i + 3 + $unsigned($random(seed)) % (12 - i);
        prog[i]   = {4'hA, rr, k[6:0], 1'b0};
        prog[i+1] = {4'hB, rr, 8'h00};
        prog[i+2] = {4'hD, r[11:9], 1'b0, rr, r[3:0]};
        // entering past the LLB would see a stale target register
        no_land[i+1] = 1'b1;
        no_land[i+2] = 1'b1;
        br_llb[i]    = 1'b1;
        i += 3;
      end else begin
        // reuse base and offset of the last store so loads hit written data
        if (op == OP_LW && r[16]) r[7:0] = last_sw[7:0];
        prog[i] = {op, r[11:0]};
        if (op == OP_SW) last_sw = prog[i];
        i++;
        // store the ALU result right away
        if (op < 4'h8 && i < 14 && r[17]) begin
          prog[i] = {4'h9, r[11:8], r[23:16]};
          last_sw = prog[i];
          i++;
        end
      end
    end
    // targets inside an LLB LHB BR group move to the word after the group
    for (i = 0; i < 14; i++) begin
      if (prog[i][15:12] == 4'hC) begin
        t = i + 1 + prog[i][8:0];
        while (no_land[t]) t++;
        k = t - i - 1;
        prog[i][8:0] = k[8:0];
      end else if (br_llb[i]) begin
        t = prog[i][7:1];
        while (no_land[t]) t++;
        prog[i][7:0] = {t[6:0], 1'b0};
      end
    end
    prog[14] = 16'hF000;
    prog[15] = 16'hF000;
  endtask

  // executes the program from pc 0 up to the first halt
  task automatic run_model();
    word_t    ins;
    word_t    a;
    word_t    res;
    word_t    addr;
    word_t    npc;
    word_t    pcv;
    reg_idx_t d;
    logic [3:0] op;
    int       sum;
    int       j;
    for (j = 0; j < 16; j++) rf[j] = '0;
    for (j = 0; j < 256; j++) dm[j] = '0;
    flag_n = 1'b0;
    flag_z = 1'b0;
    flag_v = 1'b0;
    exp_addr.delete();
    exp_data.delete();
    pcv = '0;
    model_count = 0;
    ins = prog[pcv[4:1]];
    while (ins[15:12] != 4'hF && model_count < 64) begin
      op   = ins[15:12];
      d    = ins[11:8];
      a    = rf[ins[7:4]];
      res  = rf[d];
      npc  = pcv + 16'd2;
      // even base plus signed word offset in bytes
      addr = {a[15:1], 1'b0} + {{11{ins[3]}}, ins[3:0], 1'b0};
      case (op)
        4'h0, 4'h1: begin
          // overflow taken from the exact signed sum
          sum = op[0] ? $signed(a) - $signed(rf[ins[3:0]]) : $signed(a) + $signed(rf[ins[3:0]]);
          res    = sum[15:0];
          flag_n = res[15];
          flag_v = (sum > 32767) || (sum < -32768);
        end
        4'h2: res = a ^ rf[ins[3:0]];
        4'h3: res = a & rf[ins[3:0]];
        4'h7: res = a | rf[ins[3:0]];
        4'h4: res = a << ins[3:0];
        4'h5: res = a >> ins[3:0];
        4'h6: res = $signed(a) >>> ins[3:0];
        4'h8: res = dm[addr[8:1]];
        4'h9: begin
          exp_addr.push_back(addr);
          exp_data.push_back(rf[d]);
          dm[addr[8:1]] = rf[d];
        end
        4'hA: res[7:0] = ins[7:0];
        4'hB: res[15:8] = ins[7:0];
        4'hC: if (cond_met(ins[11:9])) npc = npc + {{6{ins[8]}}, ins[8:0], 1'b0};
        4'hD: if (cond_met(ins[11:9])) npc = a;
        default: res = npc;
      endcase
      if (op < 4'h8) flag_z = (res == '0);
      // register 0 and non-writing opcodes keep the file unchanged
      if (d != 0 && op != 4'h9 && op != 4'hC && op != 4'hD) rf[d] = res;
      pcv = npc;
      model_count++;
      ins = prog[pcv[4:1]];
    end
    model_pc = pcv;
  endtask

  task automatic check_store();
    if (exp_addr.size() == 0) begin
      $display("extra store at %0t to address %h", $time, st_addr);
      errors++;
    end else begin
      check_word(st_addr, exp_addr.pop_front(), "store address");
      check_word(st_data, exp_data.pop_front(), "store data");
    end
  endtask

  // abort cuts the run short so the next test starts from a mid-run reset
  task automatic run_test(input int idx, input bit abort);
    int n;
    int j;
    int errs_before;
    errs_before = errors;
    gen_program();
    run_model();
    // load the program while the core sits in reset
    for (j = 0; j < 16; j++) begin
      @(posedge clk);
      rst_n     <= 1'b0;
      prog_we   <= 1'b1;
      prog_addr <= imem_addr_t'(j);
      prog_data <= prog[j];
      if (j == 1) begin
        @(negedge clk);
        check_word(pc, '0, "pc in reset");
        check_flag(st_en, 1'b0, "st_en in reset");
      end
    end
    @(posedge clk);
    prog_we <= 1'b0;
    rst_n   <= 1'b1;
    n = 0;
    @(negedge clk);
    // one instruction per cycle until hlt shows up
    while (hlt !== 1'b1 && n < 20 && !(abort && n == 4)) begin
      if (st_en === 1'b1) check_store();
      n++;
      @(negedge clk);
    end
    if (hlt !== 1'b1 && !abort) begin
      $display("halt never came in test %0d after %0d cycles", idx, n);
      errors++;
    end else if (hlt === 1'b1) begin
      check_word(word_t'(n), word_t'(model_count), "cycles to halt");
      check_word(pc, model_pc, "pc at halt");
      if (exp_addr.size() != 0) begin
        $display("test %0d is missing %0d stores", idx, exp_addr.size());
        errors++;
      end
      repeat (4) begin
        @(negedge clk);
        check_flag(hlt, 1'b1, "hlt after halt");
        check_flag(st_en, 1'b0, "st_en after halt");
        check_word(pc, model_pc, "pc held at halt");
      end
    end
    if (errors == errs_before) pass_cnt++;
    else fail_cnt++;
    $display("test %0d %s: %0d instructions in model, %0d cycles run%s", idx,
             (errors == errs_before) ? "ok" : "bad", model_count, n,
             (abort && hlt !== 1'b1) ? ", cut by reset" : "");
  endtask

  initial begin
    int t;
    clk       = 1'b0;
    rst_n     = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    seed      = 26;
    cycles    = 0;
    errors    = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    for (t = 0; t < NTESTS; t++) begin
      run_test(t, (t % 5) == 3);
    end
    $display("tests good %0d, bad %0d, check errors %0d", pass_cnt, fail_cnt, errors);
    if (fail_cnt == 0 && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
